//--- vlog.f
logic/tryx_pkg.sv
logic/periph_bus_pkg.sv
logic/tryx_ctrl.sv
logic/ext_access_unit.sv
logic/ext_mem.sv
logic/tryx_subsys_top.sv
tb/tryx_checker.sv
tb/tb_tryx_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the tryx subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_tryx_subsys -f vlog.f \
  -o tb_tryx_subsys > build.log 2>&1 \
  && ./obj_dir/tb_tryx_subsys > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "No verdict found in sim.log"; exit 1; }
echo "Simulation PASSED"

//--- tb/tb_tryx_subsys.sv
// Tryx subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tryx_subsys;

  localparam int          MAX_ENTRIES = 40;
  localparam logic [31:0] A_EXT       = tryx_pkg::TRYX_ADDREXT_ADDR;
  localparam logic [31:0] A_USR       = tryx_pkg::TRYX_USER_ADDR;

  logic                                                clk;
  logic                                                rst_n;
  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] core_req;
  periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] core_rsp;
  int unsigned                                         err_cnt;
  int unsigned                                         chk_cnt;

  // Stimulus table, one access per row
  string       t_name  [MAX_ENTRIES];
  int          t_core  [MAX_ENTRIES];
  logic        t_write [MAX_ENTRIES];
  logic [31:0] t_addr  [MAX_ENTRIES];
  logic [3:0]  t_be    [MAX_ENTRIES];
  logic [31:0] t_wdata [MAX_ENTRIES];
  logic [31:0] t_exp   [MAX_ENTRIES];
  logic        t_par   [MAX_ENTRIES];  // Issued together with the next row
  int          n_entries;

  integer      seed;
  logic [31:0] rnd [6];
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  tryx_subsys_top u_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .core_req_i (core_req),
    .core_rsp_o (core_rsp)
  );

  tryx_checker u_chk (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .core_req_i (core_req),
    .core_rsp_i (core_rsp),
    .err_cnt_o  (err_cnt),
    .chk_cnt_o  (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reads carry an expected value, writes carry data
  task automatic add_entry(input string name, input int core, input logic write,
                           input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data, input logic par);
    t_name[n_entries]  = name;
    t_core[n_entries]  = core;
    t_write[n_entries] = write;
    t_addr[n_entries]  = addr;
    t_be[n_entries]    = be;
    t_wdata[n_entries] = write ? data : 32'd0;
    t_exp[n_entries]   = write ? 32'd0 : data;
    t_par[n_entries]   = par;
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    // Register access
    add_entry("reg_user_wr", 0, 1, A_USR, 4'hF, 32'hA000_0000, 0);
    add_entry("reg_ext_wr", 0, 1, A_EXT, 4'hF, 32'h0, 0);
    add_entry("reg_status", 0, 0, A_EXT, 4'hF, 32'hA000_0000, 0);
    // Normal window with byte enables
    add_entry("norm_wr", 0, 1, 32'h100, 4'hF, rnd[0], 0);
    add_entry("norm_rd", 0, 0, 32'h100, 4'hF, rnd[0], 0);
    add_entry("norm_wr2", 0, 1, 32'h104, 4'hF, rnd[1], 0);
    add_entry("norm_be_wr", 0, 1, 32'h100, 4'b0101, rnd[2], 0);
    add_entry("norm_be_rd", 0, 0, 32'h100, 4'hF,
              {rnd[0][31:24], rnd[2][23:16], rnd[0][15:8], rnd[2][7:0]}, 0);
    add_entry("norm_status", 0, 0, A_USR, 4'hF, 32'h0, 0);
    // Decode error, then the error bits and addrext clear
    add_entry("dec_ext_wr", 0, 1, A_EXT, 4'hF, 32'h7, 0);
    add_entry("dec_rd", 0, 0, 32'h104, 4'hF, 32'h0, 0);
    add_entry("dec_status", 0, 0, A_EXT, 4'hF, 32'h2, 0);
    add_entry("dec_status2", 0, 0, A_USR, 4'hF, 32'h0, 0);
    add_entry("dec_after_rd", 0, 0, 32'h104, 4'hF, rnd[1], 0);
    // Protected window without and with a user tag
    add_entry("prot_ext_wr", 0, 1, A_EXT, 4'hF, 32'h1, 0);
    add_entry("prot_notag_wr", 0, 1, 32'h104, 4'hF, rnd[3], 0);
    add_entry("prot_status", 0, 0, A_EXT, 4'hF, 32'h1, 0);
    add_entry("prot_unchanged", 0, 0, 32'h104, 4'hF, rnd[1], 0);
    add_entry("prot_ext_wr2", 0, 1, A_EXT, 4'hF, 32'h1, 0);
    add_entry("prot_user_wr", 0, 1, A_USR, 4'hF, 32'h5000_0000, 0);
    add_entry("prot_tag_wr", 0, 1, 32'h108, 4'hF, rnd[3], 0);
    add_entry("prot_ext_wr3", 0, 1, A_EXT, 4'hF, 32'h1, 0);
    add_entry("prot_user_wr2", 0, 1, A_USR, 4'hF, 32'h5000_0000, 0);
    add_entry("prot_tag_rd", 0, 0, 32'h108, 4'hF, rnd[3], 0);
    add_entry("prot_status2", 0, 0, A_USR, 4'hF, 32'h0, 0);
    // Two cores at once, each with its own tryx values
    add_entry("iso_c1_ext", 1, 1, A_EXT, 4'hF, 32'h1, 0);
    add_entry("iso_c1_user", 1, 1, A_USR, 4'hF, 32'h3000_0000, 0);
    add_entry("iso_c0_ext", 0, 1, A_EXT, 4'hF, 32'h7, 0);
    add_entry("iso_c0_dec_rd", 0, 0, 32'h100, 4'hF, 32'h0, 1);
    add_entry("iso_c1_prot_rd", 1, 0, 32'h108, 4'hF, rnd[3], 0);
    add_entry("iso_c0_status", 0, 0, A_EXT, 4'hF, 32'h2, 0);
    add_entry("iso_c1_status", 1, 0, A_EXT, 4'hF, 32'h0, 0);
    add_entry("iso_c0_wr", 0, 1, 32'h10C, 4'hF, rnd[4], 1);
    add_entry("iso_c1_wr", 1, 1, 32'h110, 4'hF, rnd[5], 0);
    add_entry("iso_c0_rd", 0, 0, 32'h110, 4'hF, rnd[5], 1);
    add_entry("iso_c1_rd", 1, 0, 32'h10C, 4'hF, rnd[4], 0);
  endtask

  // Drive on the falling edge, hold until gnt, then wait for r_valid
  task automatic run_entry(input int idx);
    int c;
    c = t_core[idx];
    @(negedge clk);
    u_chk.expect_entry(c, t_name[idx], !t_write[idx], t_exp[idx]);
    core_req[c].req   = 1'b1;
    core_req[c].wen   = !t_write[idx];
    core_req[c].add   = t_addr[idx];
    core_req[c].be    = t_be[idx];
    core_req[c].wdata = t_wdata[idx];
    @(posedge clk);
    while (!core_rsp[c].gnt) @(posedge clk);
    @(negedge clk);
    core_req[c] = '0;
    @(posedge clk);
    while (!core_rsp[c].r_valid) @(posedge clk);
  endtask

  initial begin
    int idx;
    seed     = 32'h874e;
    rst_n    = 1'b0;
    core_req = '0;
    for (int i = 0; i < 6; i++) rnd[i] = $random(seed);
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idx = 0;
    while (idx < n_entries) begin
      if (t_par[idx] && idx + 1 < n_entries) begin
        fork
          run_entry(idx);
          run_entry(idx + 1);
        join
        idx += 2;
      end else begin
        run_entry(idx);
        idx++;
      end
    end
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt != 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Limit scales with the table length
  initial begin
    cycle_cnt = 0;
    @(posedge clk);
    cycle_limit = 40 * n_entries + 100;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tryx_checker.sv
// Response checker for the tryx subsystem
// Shadow model of the tryx registers and memory
`timescale 1ns/1ps
`default_nettype none

module tryx_checker (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] core_req_i,
  input  periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] core_rsp_i,
  output int unsigned                                         err_cnt_o,
  output int unsigned                                         chk_cnt_o
);

  localparam int unsigned NB = tryx_pkg::NB_CORES;

  // Access in flight on one core with the tryx values seen at grant
  typedef struct packed {
    logic                valid;
    logic                is_reg;
    logic                write;
    logic [3:0]          age;
    logic [31:0]         addr;
    logic [3:0]          be;
    logic [31:0]         wdata;
    tryx_pkg::tryx_req_t tryx;
  } pend_t;

  pend_t                  pend_q  [NB];
  tryx_pkg::tryx_req_t    tryx_sh [NB];
  periph_bus_pkg::xresp_e err_sh  [NB];
  logic [31:0]            mem_sh  [tryx_pkg::MEM_WORDS];
  // Current table entry per core
  string                  name_q  [NB];
  logic                   tbl_chk [NB];
  logic [31:0]            tbl_exp [NB];

  // Set by the stimulus before each request
  task automatic expect_entry(input int c, input string name, input logic chk,
                              input logic [31:0] exp);
    name_q[c]  = name;
    tbl_chk[c] = chk;
    tbl_exp[c] = exp;
  endtask

  task automatic compare_word(input int c, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    chk_cnt_o++;
    if (act !== exp) begin
      err_cnt_o++;
      $display("CHECK FAILED %s (core %0d, %s): expected %08h, actual %08h",
               name_q[c], c, what, exp, act);
    end
  endtask

  // Only window 0 and the tagged protected window answer OKAY
  function automatic periph_bus_pkg::xresp_e predict_resp(input tryx_pkg::tryx_req_t t);
    if (t.addrext == 32'd0) return periph_bus_pkg::OKAY;
    if (t.addrext != tryx_pkg::EXT_PROT_WINDOW) return periph_bus_pkg::DECERR;
    return (t.user != '0) ? periph_bus_pkg::OKAY : periph_bus_pkg::SLVERR;
  endfunction

  task automatic finish_access(input int c);
    pend_t                  p;
    periph_bus_pkg::xresp_e resp;
    logic [31:0]            exp;
    int unsigned            lat;
    int unsigned            idx;
    p   = pend_q[c];
    lat = p.is_reg ? 1 : 2;
    idx = 32'(p.addr[tryx_pkg::MEM_AW+1:2]);
    if (!p.valid) begin
      if (core_rsp_i[c].r_valid) begin
        err_cnt_o++;
        $display("Core %0d raised r_valid with no request outstanding", c);
      end
      return;
    end
    p.age = p.age + 4'd1;
    if (!core_rsp_i[c].r_valid) begin
      // Latency is fixed so a late answer counts as lost
      if (32'(p.age) >= lat) begin
        err_cnt_o++;
        $display("Core %0d got no response for %s within %0d cycles", c, name_q[c], lat);
        p.valid = 1'b0;
      end
      pend_q[c] = p;
      return;
    end
    compare_word(c, "latency", lat, 32'(p.age));
    if (p.is_reg) begin
      if (!p.write) begin
        exp = {tryx_sh[c].user, {(32-tryx_pkg::AXI_USER_WIDTH-2){1'b0}}, err_sh[c]};
        compare_word(c, "status", exp, core_rsp_i[c].r_rdata);
        // Status read clears the error bits
        err_sh[c] = periph_bus_pkg::OKAY;
      end
    end else begin
      resp = predict_resp(p.tryx);
      exp  = (resp == periph_bus_pkg::OKAY) ? mem_sh[idx] : 32'd0;
      if (p.write && resp == periph_bus_pkg::OKAY) begin
        for (int b = 0; b < 4; b++) begin
          if (p.be[b]) mem_sh[idx][8*b +: 8] = p.wdata[8*b +: 8];
        end
      end
      if (!p.write && resp != periph_bus_pkg::SLVERR) begin
        compare_word(c, "rdata", exp, core_rsp_i[c].r_rdata);
      end
      compare_word(c, "r_opc", 32'(resp != periph_bus_pkg::OKAY), 32'(core_rsp_i[c].r_opc));
      // Error bits follow the response and the tryx values drop
      err_sh[c]  = resp;
      tryx_sh[c] = '0;
    end
    if (tbl_chk[c] && !p.write) begin
      compare_word(c, "table value", tbl_exp[c], core_rsp_i[c].r_rdata);
    end
    p.valid   = 1'b0;
    pend_q[c] = p;
  endtask

  task automatic start_access(input int c);
    pend_t p;
    logic  reg_hit;
    reg_hit = (core_req_i[c].add == tryx_pkg::TRYX_ADDREXT_ADDR) ||
              (core_req_i[c].add == tryx_pkg::TRYX_USER_ADDR);
    // Register hits are granted in their request cycle
    if (core_req_i[c].req && reg_hit && !core_rsp_i[c].gnt) begin
      err_cnt_o++;
      $display("Core %0d register access %s was not granted at once", c, name_q[c]);
    end
    if (!(core_req_i[c].req && core_rsp_i[c].gnt)) return;
    if (pend_q[c].valid) begin
      err_cnt_o++;
      $display("Core %0d was granted %s while a request was still open", c, name_q[c]);
    end
    p.valid  = 1'b1;
    p.age    = 4'd0;
    p.is_reg = reg_hit;
    p.write  = !core_req_i[c].wen;
    p.addr   = core_req_i[c].add;
    p.be     = core_req_i[c].be;
    p.wdata  = core_req_i[c].wdata;
    p.tryx   = tryx_sh[c];
    // Register writes take effect at the grant edge
    if (p.is_reg && p.write) begin
      if (p.addr == tryx_pkg::TRYX_USER_ADDR) begin
        tryx_sh[c].user = p.wdata[31 -: tryx_pkg::AXI_USER_WIDTH];
      end else begin
        tryx_sh[c].addrext = p.wdata;
      end
    end
    pend_q[c] = p;
  endtask

  // Responses are handled before grants of the same edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      for (int c = 0; c < NB; c++) begin
        pend_q[c]  = '0;
        tryx_sh[c] = '0;
        err_sh[c]  = periph_bus_pkg::OKAY;
      end
    end else begin
      for (int c = 0; c < NB; c++) finish_access(c);
      for (int c = 0; c < NB; c++) start_access(c);
    end
  end

endmodule

`default_nettype wire

//--- logic/tryx_subsys_top.sv
// Tryx subsystem top level
`timescale 1ns/1ps
`default_nettype none

module tryx_subsys_top (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] core_req_i,
  output periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] core_rsp_o
);

  // Controller to access unit
  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] fwd_req;
  periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] fwd_rsp;
  tryx_pkg::tryx_req_t         [tryx_pkg::NB_CORES-1:0] tryx_req;
  periph_bus_pkg::xresp_e      [tryx_pkg::NB_CORES-1:0] xresp;
  logic                        [tryx_pkg::NB_CORES-1:0] xresp_valid;
  // Access unit to memory
  periph_bus_pkg::ext_req_t                             mem_req;
  periph_bus_pkg::ext_rsp_t                             mem_rsp;

  tryx_ctrl u_tryx_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (core_req_i),
    .core_rsp_o    (core_rsp_o),
    .fwd_req_o     (fwd_req),
    .fwd_rsp_i     (fwd_rsp),
    .tryx_req_o    (tryx_req),
    .xresp_i       (xresp),
    .xresp_valid_i (xresp_valid)
  );

  ext_access_unit u_ext_access_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fwd_req_i     (fwd_req),
    .fwd_rsp_o     (fwd_rsp),
    .tryx_req_i    (tryx_req),
    .xresp_o       (xresp),
    .xresp_valid_o (xresp_valid),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  ext_mem u_ext_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

//--- logic/ext_mem.sv
// Wide-address memory model
`timescale 1ns/1ps
`default_nettype none

module ext_mem (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  periph_bus_pkg::ext_req_t mem_req_i,
  output periph_bus_pkg::ext_rsp_t mem_rsp_o
);

  logic [31:0]                   mem_q [tryx_pkg::MEM_WORDS];
  logic [31:0]                   addrext;
  logic [tryx_pkg::MEM_AW-1:0]   word_idx;
  logic                          hit;
  periph_bus_pkg::xresp_e        resp;
  logic                          valid_q;
  logic [31:0]                   rdata_q;
  periph_bus_pkg::xresp_e        resp_q;

  assign addrext  = mem_req_i.addr[63:32];
  assign word_idx = mem_req_i.addr[tryx_pkg::MEM_AW+1:2];

  // Window decode
  always_comb begin
    hit  = 1'b0;
    resp = periph_bus_pkg::DECERR;
    if (addrext == '0) begin
      hit  = 1'b1;
      resp = periph_bus_pkg::OKAY;
    end else if (addrext == tryx_pkg::EXT_PROT_WINDOW) begin
      // Needs a user tag
      if (mem_req_i.user != '0) begin
        hit  = 1'b1;
        resp = periph_bus_pkg::OKAY;
      end else begin
        resp = periph_bus_pkg::SLVERR;
      end
    end
  end

  // Byte-enabled write, shared by both windows
  always_ff @(posedge clk_i) begin
    if (mem_req_i.valid && mem_req_i.write && hit) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req_i.be[b]) mem_q[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) valid_q <= 1'b0;
    else         valid_q <= mem_req_i.valid;
  end

  // Error answers carry zero data
  always_ff @(posedge clk_i) begin
    if (mem_req_i.valid) begin
      rdata_q <= hit ? mem_q[word_idx] : '0;
      resp_q  <= resp;
    end
  end

  assign mem_rsp_o.valid = valid_q;
  assign mem_rsp_o.rdata = rdata_q;
  assign mem_rsp_o.resp  = resp_q;

endmodule

`default_nettype wire

//--- logic/ext_access_unit.sv
// External access unit
`timescale 1ns/1ps
`default_nettype none

module ext_access_unit (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] fwd_req_i,
  output periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] fwd_rsp_o,
  input  tryx_pkg::tryx_req_t         [tryx_pkg::NB_CORES-1:0] tryx_req_i,
  output periph_bus_pkg::xresp_e      [tryx_pkg::NB_CORES-1:0] xresp_o,
  output logic                        [tryx_pkg::NB_CORES-1:0] xresp_valid_o,
  output periph_bus_pkg::ext_req_t                             mem_req_o,
  input  periph_bus_pkg::ext_rsp_t                             mem_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e                            state_d, state_q;
  logic [tryx_pkg::CORE_IDX_W-1:0]   last_q, cur_q, sel_idx;
  logic                              sel_found;
  logic                              grant;
  periph_bus_pkg::periph_req_t       req_q;
  tryx_pkg::tryx_req_t               tryx_q;

  // Round robin, search starts one past the last winner
  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_idx   = last_q;
    for (int unsigned k = 1; k <= tryx_pkg::NB_CORES; k++) begin
      cand = (32'(last_q) + k) % tryx_pkg::NB_CORES;
      if (!sel_found && fwd_req_i[cand].req) begin
        sel_found = 1'b1;
        sel_idx   = tryx_pkg::CORE_IDX_W'(cand);
      end
    end
  end

  // One transaction in flight at most
  assign grant = (state_q == IDLE) && sel_found;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (grant) state_d = ISSUE;
      ISSUE:   state_d = WAIT;
      WAIT:    if (mem_rsp_i.valid) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Wide address is the extension word on top of the core address
  always_comb begin
    mem_req_o.valid = (state_q == ISSUE);
    mem_req_o.write = !req_q.wen;
    mem_req_o.addr  = {tryx_q.addrext, req_q.add};
    mem_req_o.wdata = req_q.wdata;
    mem_req_o.be    = req_q.be;
    mem_req_o.user  = tryx_q.user;
  end

  // Grant and response, routed to one core only
  always_comb begin
    for (int c = 0; c < tryx_pkg::NB_CORES; c++) begin
      fwd_rsp_o[c]     = '0;
      xresp_o[c]       = periph_bus_pkg::OKAY;
      xresp_valid_o[c] = 1'b0;
      fwd_rsp_o[c].gnt = grant && (sel_idx == tryx_pkg::CORE_IDX_W'(c));
      if ((state_q == WAIT) && mem_rsp_i.valid && (cur_q == tryx_pkg::CORE_IDX_W'(c))) begin
        fwd_rsp_o[c].r_valid = 1'b1;
        fwd_rsp_o[c].r_opc   = (mem_rsp_i.resp != periph_bus_pkg::OKAY);
        fwd_rsp_o[c].r_rdata = mem_rsp_i.rdata;
        xresp_o[c]           = mem_rsp_i.resp;
        xresp_valid_o[c]     = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      last_q  <= '0;
      cur_q   <= '0;
    end else begin
      state_q <= state_d;
      if (grant) begin
        last_q <= sel_idx;
        cur_q  <= sel_idx;
      end
    end
  end

  // Request and tryx values captured at grant
  always_ff @(posedge clk_i) begin
    if (grant) begin
      req_q  <= fwd_req_i[sel_idx];
      tryx_q <= tryx_req_i[sel_idx];
    end
  end

endmodule

`default_nettype wire

//--- logic/tryx_ctrl.sv
// Tryx register control
// Per-core address extension and user tag
`timescale 1ns/1ps
`default_nettype none

module tryx_ctrl (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] core_req_i,
  output periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] core_rsp_o,
  output periph_bus_pkg::periph_req_t [tryx_pkg::NB_CORES-1:0] fwd_req_o,
  input  periph_bus_pkg::periph_rsp_t [tryx_pkg::NB_CORES-1:0] fwd_rsp_i,
  output tryx_pkg::tryx_req_t         [tryx_pkg::NB_CORES-1:0] tryx_req_o,
  input  periph_bus_pkg::xresp_e      [tryx_pkg::NB_CORES-1:0] xresp_i,
  input  logic                        [tryx_pkg::NB_CORES-1:0] xresp_valid_i
);

  for (genvar i = 0; i < tryx_pkg::NB_CORES; i++) begin : gen_core
    tryx_pkg::tryx_req_t    tryx_d, tryx_q;
    periph_bus_pkg::xresp_e err_d, err_q;
    logic                   is_reg;
    logic                   rd_en_d, rd_en_q;
    logic                   wr_en_d, wr_en_q;
    logic                   wait_d, wait_q;
    logic [31:0]            status;

    // Hit on either register address
    assign is_reg = (core_req_i[i].add == tryx_pkg::TRYX_ADDREXT_ADDR) ||
                    (core_req_i[i].add == tryx_pkg::TRYX_USER_ADDR);

    // Tag on top, error code at the bottom
    assign status = {tryx_q.user, {(32-tryx_pkg::AXI_USER_WIDTH-2){1'b0}}, err_q};

    assign tryx_req_o[i] = tryx_q;

    // Request path
    always_comb begin
      // Payload always passes, only req is held back for local hits
      fwd_req_o[i]     = core_req_i[i];
      fwd_req_o[i].req = core_req_i[i].req && !is_reg;
      rd_en_d          = 1'b0;
      wr_en_d          = 1'b0;
      if (core_req_i[i].req && is_reg) begin
        if (!core_req_i[i].wen) begin
          wr_en_d = 1'b1;
        end else if (!rd_en_q) begin
          // Second read while one is still responding is dropped
          rd_en_d = 1'b1;
        end
      end
    end

    // Response path
    always_comb begin
      // Local hits are granted at once
      core_rsp_o[i].gnt = is_reg ? core_req_i[i].req : fwd_rsp_i[i].gnt;
      if (rd_en_q || wr_en_q) begin
        core_rsp_o[i].r_valid = 1'b1;
        core_rsp_o[i].r_opc   = 1'b0;
        core_rsp_o[i].r_rdata = status;
      end else begin
        core_rsp_o[i].r_valid = fwd_rsp_i[i].r_valid;
        core_rsp_o[i].r_opc   = fwd_rsp_i[i].r_opc;
        core_rsp_o[i].r_rdata = fwd_rsp_i[i].r_rdata;
      end
    end

    // Error code of the last external response
    always_comb begin
      err_d = err_q;
      if (xresp_valid_i[i]) begin
        err_d = xresp_i[i];
      end else if (rd_en_q) begin
        // Cleared once the status has been returned
        err_d = periph_bus_pkg::OKAY;
      end
    end

    // Outstanding external access
    always_comb begin
      wait_d = wait_q;
      if (fwd_req_o[i].req && fwd_rsp_i[i].gnt) begin
        wait_d = 1'b1;
      end else if (wait_q && fwd_rsp_i[i].r_valid) begin
        wait_d = 1'b0;
      end
    end

    // Register writes, self clear after the external access completes
    always_comb begin
      tryx_d = tryx_q;
      if (wr_en_d) begin
        if (core_req_i[i].add == tryx_pkg::TRYX_USER_ADDR) begin
          tryx_d.user = core_req_i[i].wdata[31 -: tryx_pkg::AXI_USER_WIDTH];
        end else begin
          tryx_d.addrext = core_req_i[i].wdata;
        end
      end else if (wait_q && !wait_d) begin
        tryx_d = '0;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tryx_q  <= '0;
        err_q   <= periph_bus_pkg::OKAY;
        rd_en_q <= 1'b0;
        wr_en_q <= 1'b0;
        wait_q  <= 1'b0;
      end else begin
        tryx_q  <= tryx_d;
        err_q   <= err_d;
        rd_en_q <= rd_en_d;
        wr_en_q <= wr_en_d;
        wait_q  <= wait_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/periph_bus_pkg.sv
// Peripheral bus and external transaction types
`default_nettype none

package periph_bus_pkg;

  // Response code, decerr bit above slverr bit
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b01,
    DECERR = 2'b10
  } xresp_e;

  // One core request, held until gnt
  typedef struct packed {
    logic        req;
    logic        wen;   // Low for a write
    logic [31:0] add;
    logic [3:0]  be;
    logic [31:0] wdata;
  } periph_req_t;

  // Response toward one core
  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic        r_opc;  // Set on an error response
    logic [31:0] r_rdata;
  } periph_rsp_t;

  // Single transaction toward the memory
  typedef struct packed {
    logic                                valid;
    logic                                write;
    logic [63:0]                         addr;   // Extension word above the core address
    logic [31:0]                         wdata;
    logic [3:0]                          be;
    logic [tryx_pkg::AXI_USER_WIDTH-1:0] user;
  } ext_req_t;

  // Memory answer, one cycle after the request
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    xresp_e      resp;
  } ext_rsp_t;

endpackage

`default_nettype wire

//--- logic/tryx_pkg.sv
// Tryx cluster constants
// Register map, tag width and memory windows
`default_nettype none

package tryx_pkg;

  // Cluster size
  localparam int unsigned NB_CORES = 2;
  // Width of a core index, at least one bit
  localparam int unsigned CORE_IDX_W = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;

  // AXI user tag carried with every external access
  localparam int unsigned AXI_USER_WIDTH = 4;

  // Per-core register addresses on the peripheral bus
  localparam logic [31:0] TRYX_ADDREXT_ADDR = 32'h1020_0BF8;
  localparam logic [31:0] TRYX_USER_ADDR    = 32'h1020_0BFC;

  // Values sent along with the next external access
  typedef struct packed {
    logic [31:0]               addrext;
    logic [AXI_USER_WIDTH-1:0] user;
  } tryx_req_t;

  // Memory model depth in 32-bit words
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // Upper address word of the tag-protected window
  // Window 0 is the normal window, all others decode to an error
  localparam logic [31:0] EXT_PROT_WINDOW = 32'd1;

endpackage

`default_nettype wire
